// File: logic/dma_pkg.sv
/*
 * Shared widths, types and sizing for the host-to-user streaming path.
 * Every RTL block pulls these in through a wildcard import.
 */
package dma_pkg;

    // ----------------------------------------
    // Sizing
    // ----------------------------------------
    localparam int NUM_STRM      = 4;
    localparam int MAX_REQ_BYTES = 128;
    localparam int BEAT_BYTES    = 8;
    localparam int MAX_REQ_BEATS = MAX_REQ_BYTES / BEAT_BYTES;
    localparam int FIFO_DEPTH    = 32;
    localparam int FIFO_AW       = $clog2(FIFO_DEPTH);
    localparam int REG_STRIDE    = 4;

    // ----------------------------------------
    // Data types
    // ----------------------------------------
    typedef logic [31:0] addr_t;
    typedef logic [31:0] len_t;
    typedef logic [11:0] req_len_t;
    typedef logic [7:0]  tag_t;
    typedef logic [63:0] qword_t;
    typedef logic [9:0]  reg_addr_t;
    typedef logic [31:0] reg_data_t;
    typedef logic [1:0]  reg_off_t;
    typedef logic [$clog2(NUM_STRM)-1:0] chan_idx_t;

    // Word offsets inside one channel's register block
    localparam reg_off_t REG_SRC_ADDR = 2'd0;
    localparam reg_off_t REG_LEN      = 2'd1;
    localparam reg_off_t REG_CTRL     = 2'd2;
    localparam reg_off_t REG_STATUS   = 2'd3;

    typedef enum logic [1:0] {
        IDLE,
        REQUEST,
        RECEIVE,
        DRAIN
    } chan_state_t;

endpackage

// File: logic/dma_req_if.sv
`timescale 1ns/1ps
/*
 * Read request from one stream channel towards the request arbiter.
 * The channel holds req and its fields until the one-cycle ack.
 */
interface dma_req_if import dma_pkg::*; ();

    logic     req;
    addr_t    addr;
    req_len_t len;
    tag_t     tag;
    logic     ack;

    modport source (
        output req,
        output addr,
        output len,
        output tag,
        input  ack
    );

    modport sink (
        input  req,
        input  addr,
        input  len,
        input  tag,
        output ack
    );

endinterface

// File: logic/chan_ctrl_if.sv
`timescale 1ns/1ps
/*
 * Control and status between the register block and one stream channel.
 */
interface chan_ctrl_if import dma_pkg::*; ();

    logic  start;
    addr_t src_addr;
    len_t  length;
    logic  busy;
    logic  done;

    modport ctrl (
        output start,
        output src_addr,
        output length,
        input  busy,
        input  done
    );

    modport chan (
        input  start,
        input  src_addr,
        input  length,
        output busy,
        output done
    );

endinterface

// File: logic/reg_file.sv
`timescale 1ns/1ps
/*
 * Host register block. Each channel owns REG_STRIDE words holding the
 * source address, the length, a start bit and a status word.
 * Writes land on the next cycle, reads answer one cycle after reg_rd_i.
 */
module reg_file import dma_pkg::*; (
    input  logic      clk_i,
    input  logic      reset_i,
    input  logic      reg_wr_i,
    input  logic      reg_rd_i,
    input  reg_addr_t reg_addr_i,
    input  reg_data_t reg_data_i,
    output reg_data_t reg_data_o,
    output logic      reg_rd_ack_o,
    chan_ctrl_if.ctrl ctrl [NUM_STRM]
);

    reg_addr_t             reg_chan;
    reg_off_t              reg_off;
    chan_idx_t             chan_idx;
    logic                  chan_ok;
    reg_data_t             rd_val;

    addr_t                 src_addr_q [NUM_STRM];
    len_t                  len_q [NUM_STRM];
    logic [NUM_STRM-1:0]   start_q;
    logic [NUM_STRM-1:0]   busy_vec;
    logic [NUM_STRM-1:0]   done_vec;

    // ----------------------------------------
    // Address decode
    // ----------------------------------------
    assign reg_chan = reg_addr_i / reg_addr_t'(REG_STRIDE);
    assign reg_off  = reg_off_t'(reg_addr_i % reg_addr_t'(REG_STRIDE));
    assign chan_idx = chan_idx_t'(reg_chan);
    assign chan_ok  = reg_chan < reg_addr_t'(NUM_STRM);

    always_ff @(posedge clk_i) begin
        if (reset_i)
        begin
            for (int c = 0; c < NUM_STRM; c++)
            begin
                src_addr_q[c] <= '0;
                len_q[c]      <= '0;
            end
            start_q <= '0;
        end
        else
        begin
            // Start is a single-cycle pulse
            start_q <= '0;
            if (reg_wr_i && chan_ok)
            begin
                case (reg_off)
                    REG_SRC_ADDR: src_addr_q[chan_idx] <= reg_data_i;
                    REG_LEN:      len_q[chan_idx]      <= reg_data_i;
                    REG_CTRL:     start_q[chan_idx]    <= reg_data_i[0];
                    default:      ;
                endcase
            end
        end
    end

    // ----------------------------------------
    // Read path
    // ----------------------------------------
    always_comb begin
        rd_val = '0;
        if (chan_ok)
        begin
            case (reg_off)
                REG_SRC_ADDR: rd_val = src_addr_q[chan_idx];
                REG_LEN:      rd_val = len_q[chan_idx];
                REG_STATUS:   rd_val = reg_data_t'({done_vec[chan_idx], busy_vec[chan_idx]});
                default:      rd_val = '0;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i)
            reg_rd_ack_o <= 1'b0;
        else
            reg_rd_ack_o <= reg_rd_i;
    end

    always_ff @(posedge clk_i) begin
        if (reg_rd_i)
            reg_data_o <= rd_val;
    end

    for (genvar c = 0; c < NUM_STRM; c++) begin : g_ctrl
        assign ctrl[c].start    = start_q[c];
        assign ctrl[c].src_addr = src_addr_q[c];
        assign ctrl[c].length   = len_q[c];
        assign busy_vec[c]      = ctrl[c].busy;
        assign done_vec[c]      = ctrl[c].done;
    end

    a_no_wr_rd: assert property (@(posedge clk_i) disable iff (reset_i)
        !(reg_wr_i && reg_rd_i));

endmodule

// File: logic/stream_channel.sv
`timescale 1ns/1ps
/*
 * One host-to-user stream channel. A start splits the transfer into
 * read requests of up to MAX_REQ_BYTES, completions tagged CHAN_ID fill
 * a local buffer, and the buffer drains over a valid/ready stream.
 */
module stream_channel import dma_pkg::*; #(
    parameter int CHAN_ID = 0
) (
    input  logic      clk_i,
    input  logic      reset_i,
    chan_ctrl_if.chan ctrl,
    dma_req_if.source req,
    input  logic      cpld_valid_i,
    input  tag_t      cpld_tag_i,
    input  qword_t    cpld_data_i,
    output logic      str_valid_o,
    input  logic      str_ready_i,
    output qword_t    str_data_o
);

    chan_state_t        state_q;
    addr_t              cur_addr_q;
    len_t               remain_q;
    req_len_t           rx_left_q;
    req_len_t           req_len;
    logic               busy_q;
    logic               done_q;
    logic               len_ok;
    logic               room;
    logic               req_valid;
    logic               accept;
    logic               push;
    logic               pop;

    qword_t             buf_mem [FIFO_DEPTH];
    logic [FIFO_AW-1:0] wr_ptr_q;
    logic [FIFO_AW-1:0] rd_ptr_q;
    logic [FIFO_AW:0]   count_q;

    // Full-size request or the tail of the transfer
    assign req_len = (remain_q >= len_t'(MAX_REQ_BYTES)) ? req_len_t'(MAX_REQ_BYTES)
                                                         : req_len_t'(remain_q);
    assign len_ok  = (ctrl.length != '0) && ((ctrl.length % len_t'(BEAT_BYTES)) == '0);
    assign room    = (int'(count_q) + MAX_REQ_BEATS) <= FIFO_DEPTH;

    assign req_valid = (state_q == REQUEST) && room;
    assign accept    = req_valid && req.ack;
    assign push      = cpld_valid_i && (cpld_tag_i == tag_t'(CHAN_ID)) && (state_q == RECEIVE);
    assign pop       = str_valid_o && str_ready_i;

    assign req.req  = req_valid;
    assign req.addr = cur_addr_q;
    assign req.len  = req_len;
    assign req.tag  = tag_t'(CHAN_ID);

    assign ctrl.busy = busy_q;
    assign ctrl.done = done_q;

    // ----------------------------------------
    // Channel FSM
    // ----------------------------------------
    always_ff @(posedge clk_i) begin
        if (reset_i)
        begin
            state_q <= IDLE;
            busy_q  <= 1'b0;
            done_q  <= 1'b0;
        end
        else
        begin
            case (state_q)
                IDLE:
                    if (ctrl.start && len_ok)
                    begin
                        state_q <= REQUEST;
                        busy_q  <= 1'b1;
                        done_q  <= 1'b0;
                    end
                REQUEST:
                    if (accept)
                        state_q <= RECEIVE;
                RECEIVE:
                    if (push && rx_left_q == req_len_t'(BEAT_BYTES))
                        state_q <= (remain_q == '0) ? DRAIN : REQUEST;
                DRAIN:
                    if (count_q == '0)
                    begin
                        state_q <= IDLE;
                        busy_q  <= 1'b0;
                        done_q  <= 1'b1;
                    end
                default:
                    state_q <= IDLE;
            endcase
        end
    end

    // Address and byte counters
    always_ff @(posedge clk_i) begin
        if (state_q == IDLE && ctrl.start)
        begin
            cur_addr_q <= ctrl.src_addr;
            remain_q   <= ctrl.length;
        end
        if (accept)
        begin
            cur_addr_q <= cur_addr_q + addr_t'(req_len);
            remain_q   <= remain_q - len_t'(req_len);
            rx_left_q  <= req_len;
        end
        else if (push)
            rx_left_q <= rx_left_q - req_len_t'(BEAT_BYTES);
    end

    // ----------------------------------------
    // Beat buffer
    // ----------------------------------------
    always_ff @(posedge clk_i) begin
        if (push)
            buf_mem[wr_ptr_q] <= cpld_data_i;
    end

    always_ff @(posedge clk_i) begin
        if (reset_i)
        begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end
        else
        begin
            if (push)
                wr_ptr_q <= wr_ptr_q + 1'b1;
            if (pop)
                rd_ptr_q <= rd_ptr_q + 1'b1;
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    assign str_valid_o = (count_q != '0);
    assign str_data_o  = buf_mem[rd_ptr_q];

    a_len_ok: assert property (@(posedge clk_i) disable iff (reset_i)
        ctrl.start |-> len_ok);

    a_no_overflow: assert property (@(posedge clk_i) disable iff (reset_i)
        push |-> (int'(count_q) < FIFO_DEPTH));

    a_req_stable: assert property (@(posedge clk_i) disable iff (reset_i)
        (req_valid && !req.ack) |=>
            (req_valid && $stable(req.addr) && $stable(req.len) && $stable(req.tag)));

endmodule

// File: logic/dma_req_arbiter.sv
`timescale 1ns/1ps
/*
 * Round-robin arbiter for the channel read requests. The winner's fields
 * are registered and held on the outgoing port until dma_req_ack_i,
 * which goes back to the granted channel in the same cycle.
 */
module dma_req_arbiter import dma_pkg::*; (
    input  logic      clk_i,
    input  logic      reset_i,
    dma_req_if.sink   chan [NUM_STRM],
    output logic      dma_req_o,
    output addr_t     dma_req_addr_o,
    output req_len_t  dma_req_len_o,
    output tag_t      dma_req_tag_o,
    input  logic      dma_req_ack_i
);

    logic [NUM_STRM-1:0] req_vec;
    logic [NUM_STRM-1:0] ack_vec;
    addr_t               req_addr [NUM_STRM];
    req_len_t            req_len [NUM_STRM];
    tag_t                req_tag [NUM_STRM];

    chan_idx_t           last_q;
    chan_idx_t           pick;
    logic                found;
    logic                out_valid_q;

    for (genvar c = 0; c < NUM_STRM; c++)
    begin : g_chan
        assign req_vec[c]  = chan[c].req;
        assign req_addr[c] = chan[c].addr;
        assign req_len[c]  = chan[c].len;
        assign req_tag[c]  = chan[c].tag;
        assign ack_vec[c]  = dma_req_ack_i && out_valid_q && (last_q == chan_idx_t'(c));
        assign chan[c].ack = ack_vec[c];
    end

    // Search starts one past the last winner
    always_comb
    begin
        int idx;
        found = 1'b0;
        pick  = last_q;
        for (int i = 1; i <= NUM_STRM; i++)
        begin
            idx = (int'(last_q) + i) % NUM_STRM;
            if (!found && req_vec[idx])
            begin
                found = 1'b1;
                pick  = chan_idx_t'(idx);
            end
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (reset_i)
        begin
            out_valid_q <= 1'b0;
            last_q      <= chan_idx_t'(NUM_STRM - 1);
        end
        else if (out_valid_q)
        begin
            if (dma_req_ack_i)
                out_valid_q <= 1'b0;
        end
        else if (found)
        begin
            out_valid_q <= 1'b1;
            last_q      <= pick;
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (!out_valid_q && found)
        begin
            dma_req_addr_o <= req_addr[pick];
            dma_req_len_o  <= req_len[pick];
            dma_req_tag_o  <= req_tag[pick];
        end
    end

    assign dma_req_o = out_valid_q;

    a_ack_with_req: assert property (@(posedge clk_i) disable iff (reset_i)
        dma_req_ack_i |-> dma_req_o);

    // The acknowledged channel must still be holding its request
    a_one_ack: assert property (@(posedge clk_i) disable iff (reset_i)
        $onehot0(ack_vec) && ((ack_vec & ~req_vec) == '0));

endmodule

// File: logic/pcie_app.sv
`timescale 1ns/1ps
/*
 * Application top for the host-to-user streaming path. Host register
 * accesses set up the channels, the arbiter forwards their read requests,
 * and completion beats are broadcast to all channels by tag.
 */
module pcie_app import dma_pkg::*; (
    input  logic                      pcie_core_clk_i,
    input  logic                      reset_i,
    // Register access
    input  logic                      reg_wr_i,
    input  logic                      reg_rd_i,
    input  reg_addr_t                 reg_addr_i,
    input  reg_data_t                 reg_data_i,
    output reg_data_t                 reg_data_o,
    output logic                      reg_rd_ack_o,
    // Outgoing read requests
    output logic                      dma_req_o,
    output addr_t                     dma_req_addr_o,
    output req_len_t                  dma_req_len_o,
    output tag_t                      dma_req_tag_o,
    input  logic                      dma_req_ack_i,
    // Completion beats
    input  logic                      cpld_valid_i,
    input  tag_t                      cpld_tag_i,
    input  qword_t                    cpld_data_i,
    // User streams
    output logic   [NUM_STRM-1:0]     str_valid_o,
    input  logic   [NUM_STRM-1:0]     str_ready_i,
    output qword_t [NUM_STRM-1:0]     str_data_o
);

    chan_ctrl_if ctrl_if [NUM_STRM] ();
    dma_req_if   req_if  [NUM_STRM] ();

    reg_file u_reg_file (
        .clk_i        (pcie_core_clk_i),
        .reset_i      (reset_i),
        .reg_wr_i     (reg_wr_i),
        .reg_rd_i     (reg_rd_i),
        .reg_addr_i   (reg_addr_i),
        .reg_data_i   (reg_data_i),
        .reg_data_o   (reg_data_o),
        .reg_rd_ack_o (reg_rd_ack_o),
        .ctrl         (ctrl_if)
    );

    // ----------------------------------------
    // Stream channels
    // ----------------------------------------
    for (genvar c = 0; c < NUM_STRM; c++) begin : g_strm
        stream_channel #(
            .CHAN_ID (c)
        ) u_chan (
            .clk_i        (pcie_core_clk_i),
            .reset_i      (reset_i),
            .ctrl         (ctrl_if[c]),
            .req          (req_if[c]),
            .cpld_valid_i (cpld_valid_i),
            .cpld_tag_i   (cpld_tag_i),
            .cpld_data_i  (cpld_data_i),
            .str_valid_o  (str_valid_o[c]),
            .str_ready_i  (str_ready_i[c]),
            .str_data_o   (str_data_o[c])
        );
    end

    dma_req_arbiter u_arbiter (
        .clk_i          (pcie_core_clk_i),
        .reset_i        (reset_i),
        .chan           (req_if),
        .dma_req_o      (dma_req_o),
        .dma_req_addr_o (dma_req_addr_o),
        .dma_req_len_o  (dma_req_len_o),
        .dma_req_tag_o  (dma_req_tag_o),
        .dma_req_ack_i  (dma_req_ack_i)
    );

endmodule

// File: test/tb_checks.svh
/*
 * Reference model and typed compare tasks for the streaming testbench.
 * Included inside the testbench module. Every mismatch bumps a counter.
 */
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int value_errors = 0;
int other_errors = 0;

// Beat k of a transfer that starts at byte address start
function automatic qword_t expected_beat(input addr_t start, input int k);
    addr_t a;
    a = start + addr_t'(k * BEAT_BYTES);
    return {a, ~a};
endfunction

task automatic check_beat(input string name, input qword_t got, input qword_t exp);
    if (got !== exp)
    begin
        value_errors++;
        $display("error at %0t: %s = %h, expected %h", $time, name, got, exp);
    end
endtask

task automatic verify_reg(input string name, input reg_data_t got, input reg_data_t exp);
    if (got !== exp)
    begin
        value_errors++;
        $display("error at %0t: %s = %h, expected %h", $time, name, got, exp);
    end
endtask

task automatic compare_addr(input string name, input addr_t got, input addr_t exp);
    if (got !== exp)
    begin
        value_errors++;
        $display("error at %0t: %s = %h, expected %h", $time, name, got, exp);
    end
endtask

task automatic expect_len(input string name, input req_len_t got, input req_len_t exp);
    if (got !== exp)
    begin
        value_errors++;
        $display("error at %0t: %s = %0d, expected %0d", $time, name, got, exp);
    end
endtask

task automatic expect_tag(input string name, input tag_t got, input tag_t exp);
    if (got !== exp)
    begin
        value_errors++;
        $display("error at %0t: %s = %0d, expected %0d", $time, name, got, exp);
    end
endtask

`endif

// File: test/tb_pcie_app.sv
`timescale 1ns/1ps
/*
 * Testbench for pcie_app. A host memory model answers read requests with
 * interleaved completion beats, a stream sink checks every user beat
 * against the reference, and the main sequence drives the register bus.
 */
module tb_pcie_app import dma_pkg::*; ();

    localparam int DONE_POLLS = 2000;

    logic                  clk = 1'b0;
    logic                  reset_i;
    logic                  reg_wr_i;
    logic                  reg_rd_i;
    reg_addr_t             reg_addr_i;
    reg_data_t             reg_data_i;
    reg_data_t             reg_data_o;
    logic                  reg_rd_ack_o;
    logic                  dma_req_o;
    addr_t                 dma_req_addr_o;
    req_len_t              dma_req_len_o;
    tag_t                  dma_req_tag_o;
    logic                  dma_req_ack_i = 1'b0;
    logic                  cpld_valid_i = 1'b0;
    tag_t                  cpld_tag_i = '0;
    qword_t                cpld_data_i = '0;
    logic   [NUM_STRM-1:0] str_valid_o;
    logic   [NUM_STRM-1:0] str_ready_i = '0;
    qword_t [NUM_STRM-1:0] str_data_o;

    // Expected transfers, set by the main sequence
    addr_t exp_start [NUM_STRM];
    len_t  exp_len [NUM_STRM];
    int    exp_beats [NUM_STRM];
    int    start_gen [NUM_STRM];
    logic  backpressure;

    // Host memory model
    addr_t pend_addr [NUM_STRM][$];
    addr_t exp_req_addr [NUM_STRM];
    len_t  exp_remain [NUM_STRM];
    int    req_gen [NUM_STRM];
    int    ack_delay;
    int    send_tag;
    int    first_tag;
    addr_t beat_addr;

    // Stream sink
    int    rx_count [NUM_STRM];
    int    rx_gen [NUM_STRM];

    `include "tb_checks.svh"

    pcie_app u_dut (
        .pcie_core_clk_i (clk),
        .reset_i         (reset_i),
        .reg_wr_i        (reg_wr_i),
        .reg_rd_i        (reg_rd_i),
        .reg_addr_i      (reg_addr_i),
        .reg_data_i      (reg_data_i),
        .reg_data_o      (reg_data_o),
        .reg_rd_ack_o    (reg_rd_ack_o),
        .dma_req_o       (dma_req_o),
        .dma_req_addr_o  (dma_req_addr_o),
        .dma_req_len_o   (dma_req_len_o),
        .dma_req_tag_o   (dma_req_tag_o),
        .dma_req_ack_i   (dma_req_ack_i),
        .cpld_valid_i    (cpld_valid_i),
        .cpld_tag_i      (cpld_tag_i),
        .cpld_data_i     (cpld_data_i),
        .str_valid_o     (str_valid_o),
        .str_ready_i     (str_ready_i),
        .str_data_o      (str_data_o)
    );

    always #4 clk = ~clk;

    // Host memory content at byte address a
    function automatic qword_t memory_word(input addr_t a);
        return {a, ~a};
    endfunction

    function automatic reg_addr_t reg_word(input int c, input reg_off_t off);
        return reg_addr_t'(c * REG_STRIDE + int'(off));
    endfunction

    // Request, stream and read strobes all read low out of reset
    task automatic check_outputs_idle();
        if (dma_req_o !== 1'b0)
        begin
            value_errors++;
            $display("error at %0t: dma_req_o = %b, expected 0", $time, dma_req_o);
        end
        if (str_valid_o !== '0)
        begin
            value_errors++;
            $display("error at %0t: str_valid_o = %b, expected 0", $time, str_valid_o);
        end
        if (reg_rd_ack_o !== 1'b0)
        begin
            value_errors++;
            $display("error at %0t: reg_rd_ack_o = %b, expected 0", $time, reg_rd_ack_o);
        end
    endtask

    // ----------------------------------------
    // Register bus
    // ----------------------------------------
    task automatic write_reg(input reg_addr_t addr, input reg_data_t data);
        reg_wr_i   = 1'b1;
        reg_addr_i = addr;
        reg_data_i = data;
        @(negedge clk);
        reg_wr_i = 1'b0;
    endtask

    task automatic read_reg(input reg_addr_t addr, output reg_data_t data);
        reg_rd_i   = 1'b1;
        reg_addr_i = addr;
        @(negedge clk);
        reg_rd_i = 1'b0;
        data     = reg_data_o;
        if (reg_rd_ack_o !== 1'b1)
        begin
            other_errors++;
            $display("Read of word %0d got no reg_rd_ack_o one cycle after reg_rd_i", addr);
        end
        @(negedge clk);
        if (reg_rd_ack_o !== 1'b0)
        begin
            other_errors++;
            $display("reg_rd_ack_o stayed high for more than one cycle at %0t", $time);
        end
    endtask

    task automatic start_channel(input int c, input addr_t src, input len_t len);
        exp_start[c] = src;
        exp_len[c]   = len;
        exp_beats[c] = int'(len / len_t'(BEAT_BYTES));
        start_gen[c]++;
        write_reg(reg_word(c, REG_SRC_ADDR), src);
        write_reg(reg_word(c, REG_LEN), len);
        write_reg(reg_word(c, REG_CTRL), reg_data_t'(1));
        // Let the stale done clear before polling
        @(negedge clk);
        @(negedge clk);
    endtask

    task automatic wait_done(input int c);
        reg_data_t status;
        int        polls;
        status = '0;
        polls  = 0;
        while (!status[1] && polls < DONE_POLLS)
        begin
            read_reg(reg_word(c, REG_STATUS), status);
            polls++;
        end
        if (!status[1])
        begin
            other_errors++;
            $display("Timeout: channel %0d never reported done", c);
        end
    endtask

    task automatic finish_transfer(input int c);
        reg_data_t status;
        wait_done(c);
        read_reg(reg_word(c, REG_STATUS), status);
        verify_reg($sformatf("status of channel %0d", c), status, reg_data_t'(2));
        if (rx_count[c] != exp_beats[c])
        begin
            value_errors++;
            $display("error at %0t: beats on str_data_o[%0d] = %0d, expected %0d",
                     $time, c, rx_count[c], exp_beats[c]);
        end
        if (exp_remain[c] != '0)
        begin
            value_errors++;
            $display("error at %0t: unrequested bytes of channel %0d = %0d, expected 0",
                     $time, c, exp_remain[c]);
        end
    endtask

    // Checks one acknowledged request and queues its completion beats
    task automatic take_request();
        int       c;
        req_len_t exp_l;
        c = int'(dma_req_addr_o[31:28]) - 1;
        if (c < 0 || c >= NUM_STRM)
        begin
            other_errors++;
            $display("Request at address %h belongs to no channel", dma_req_addr_o);
        end
        else
        begin
            if (pend_addr[c].size() != 0)
            begin
                other_errors++;
                $display("Channel %0d issued a request before its previous data arrived", c);
            end
            exp_l = (exp_remain[c] >= len_t'(MAX_REQ_BYTES)) ? req_len_t'(MAX_REQ_BYTES)
                                                             : req_len_t'(exp_remain[c]);
            compare_addr("dma_req_addr_o", dma_req_addr_o, exp_req_addr[c]);
            expect_len("dma_req_len_o", dma_req_len_o, exp_l);
            expect_tag("dma_req_tag_o", dma_req_tag_o, tag_t'(c));
            exp_req_addr[c] = exp_req_addr[c] + addr_t'(exp_l);
            exp_remain[c]   = exp_remain[c] - len_t'(exp_l);
            for (int b = 0; b < int'(dma_req_len_o) / BEAT_BYTES; b++)
                pend_addr[c].push_back(dma_req_addr_o + addr_t'(b * BEAT_BYTES));
        end
    endtask

    // ----------------------------------------
    // Host memory model
    // ----------------------------------------
    always @(negedge clk)
    begin
        if (reset_i)
        begin
            dma_req_ack_i = 1'b0;
            cpld_valid_i  = 1'b0;
            ack_delay     = -1;
            for (int c = 0; c < NUM_STRM; c++)
            begin
                pend_addr[c].delete();
                req_gen[c] = 0;
            end
        end
        else
        begin
            for (int c = 0; c < NUM_STRM; c++)
            begin
                if (req_gen[c] != start_gen[c])
                begin
                    req_gen[c]      = start_gen[c];
                    exp_req_addr[c] = exp_start[c];
                    exp_remain[c]   = exp_len[c];
                end
            end
            // Random tag among the queued ones, with some idle cycles
            cpld_valid_i = 1'b0;
            send_tag     = -1;
            if ($urandom_range(3, 0) != 0)
            begin
                first_tag = int'($urandom_range(NUM_STRM - 1, 0));
                for (int i = 0; i < NUM_STRM; i++)
                    if (send_tag < 0 && pend_addr[(first_tag + i) % NUM_STRM].size() > 0)
                        send_tag = (first_tag + i) % NUM_STRM;
            end
            if (send_tag >= 0)
            begin
                beat_addr    = pend_addr[send_tag].pop_front();
                cpld_valid_i = 1'b1;
                cpld_tag_i   = tag_t'(send_tag);
                cpld_data_i  = memory_word(beat_addr);
            end
            // Beats queued here go out from the next cycle on
            dma_req_ack_i = 1'b0;
            if (dma_req_o)
            begin
                if (ack_delay < 0)
                    ack_delay = int'($urandom_range(4, 0));
                if (ack_delay == 0)
                begin
                    dma_req_ack_i = 1'b1;
                    take_request();
                    ack_delay = -1;
                end
                else
                    ack_delay--;
            end
        end
    end

    // ----------------------------------------
    // Stream sink and compare
    // ----------------------------------------
    always @(negedge clk)
    begin
        if (reset_i)
        begin
            str_ready_i = '0;
            for (int c = 0; c < NUM_STRM; c++)
            begin
                rx_count[c] = 0;
                rx_gen[c]   = 0;
            end
        end
        else
        begin
            for (int c = 0; c < NUM_STRM; c++)
            begin
                if (rx_gen[c] != start_gen[c])
                begin
                    rx_gen[c]   = start_gen[c];
                    rx_count[c] = 0;
                end
                str_ready_i[c] = !backpressure || ($urandom_range(1, 0) == 1);
                // Valid and ready now mean a transfer at the next rising edge
                if (str_valid_o[c] && str_ready_i[c])
                begin
                    if (rx_count[c] < exp_beats[c])
                        check_beat($sformatf("str_data_o[%0d]", c), str_data_o[c],
                                   expected_beat(exp_start[c], rx_count[c]));
                    else
                    begin
                        other_errors++;
                        $display("Channel %0d streamed a beat beyond its transfer", c);
                    end
                    rx_count[c]++;
                end
            end
        end
    end

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial
    begin
        reg_data_t rd;
        int        xfer_len;
        void'($urandom(45));
        reset_i      = 1'b1;
        reg_wr_i     = 1'b0;
        reg_rd_i     = 1'b0;
        reg_addr_i   = '0;
        reg_data_i   = '0;
        backpressure = 1'b0;
        for (int c = 0; c < NUM_STRM; c++)
        begin
            exp_start[c] = '0;
            exp_len[c]   = '0;
            exp_beats[c] = 0;
            start_gen[c] = 0;
        end
        repeat (8) @(negedge clk);
        reset_i = 1'b0;
        @(negedge clk);
        check_outputs_idle();

        // Register readback
        for (int c = 0; c < NUM_STRM; c++)
        begin
            write_reg(reg_word(c, REG_SRC_ADDR), reg_data_t'(32'h8000_1000 + c * 32'h10_0040));
            write_reg(reg_word(c, REG_LEN), reg_data_t'(64 + c * 8));
        end
        for (int c = 0; c < NUM_STRM; c++)
        begin
            read_reg(reg_word(c, REG_SRC_ADDR), rd);
            verify_reg("reg_data_o", rd, reg_data_t'(32'h8000_1000 + c * 32'h10_0040));
            read_reg(reg_word(c, REG_LEN), rd);
            verify_reg("reg_data_o", rd, reg_data_t'(64 + c * 8));
            read_reg(reg_word(c, REG_STATUS), rd);
            verify_reg("reg_data_o", rd, '0);
        end
        read_reg(reg_word(NUM_STRM, REG_SRC_ADDR), rd);
        verify_reg("reg_data_o", rd, '0);

        // Request splitting on one channel
        xfer_len = 1000 - (1000 % BEAT_BYTES);
        start_channel(2, 32'h3000_0100, len_t'(xfer_len));
        finish_transfer(2);

        // Single channel data
        start_channel(0, 32'h1000_0040, len_t'(384));
        finish_transfer(0);

        // All channels at once
        for (int c = 0; c < NUM_STRM; c++)
            start_channel(c, addr_t'((c + 1) << 28) + addr_t'(c * 128), len_t'(256 + c * 264));
        for (int c = 0; c < NUM_STRM; c++)
            finish_transfer(c);

        // Random stalls on the user streams
        backpressure = 1'b1;
        for (int c = 0; c < NUM_STRM; c++)
            start_channel(c, addr_t'((c + 1) << 28) + addr_t'(32'h8000 + c * 8),
                          len_t'(1024 - c * 296));
        for (int c = 0; c < NUM_STRM; c++)
            finish_transfer(c);
        backpressure = 1'b0;

        $display("Checks finished: %0d value errors, %0d other errors",
                 value_errors, other_errors);
        if (value_errors + other_errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

// File: all.f
+incdir+test
logic/dma_pkg.sv
logic/dma_req_if.sv
logic/chan_ctrl_if.sv
logic/reg_file.sv
logic/stream_channel.sv
logic/dma_req_arbiter.sv
logic/pcie_app.sv
test/tb_pcie_app.sv

// File: Makefile
SIM := obj_dir/Vtb_pcie_app

all: run

$(SIM): all.f $(wildcard logic/*.sv test/*.sv test/*.svh)
	verilator --binary --timing --assert --top-module tb_pcie_app -f all.f

run: $(SIM)
	./$(SIM) > sim.log 2>&1; status=$$?; cat sim.log; exit $$status
	! grep -q "Done: errors found" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
